// ==== source/stream_router_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// build constants of the stream router
// number of output ports, tdata width and destination queue depth
////////////////////////////////////////////////////////////////////////////

`ifndef STREAM_ROUTER_DEFS_SVH
`define STREAM_ROUTER_DEFS_SVH

// number of stream output ports served by the demultiplexer
`define ROUTER_NUM_PORTS 4

// width of one tdata word
`define ROUTER_DATA_WIDTH 32

// destination queue depth, must be a power of two for the Gray pointers
// (the queue needs at least two entries)
`define ROUTER_QUEUE_DEPTH 4

`endif

// ==== source/stream_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// stream payload types
// data word of one beat and the per-port handshake vector
////////////////////////////////////////////////////////////////////////////

`include "stream_router_defs.svh"

package stream_pkg;

    // one beat of tdata
    typedef logic [`ROUTER_DATA_WIDTH-1:0] data_t;

    // one bit per output port, used for the tvalid and tready vectors
    // bit k belongs to output port k
    typedef logic [`ROUTER_NUM_PORTS-1:0] port_vec_t;

endpackage

// ==== source/route_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// routing types
// destination index and destination queue pointer
////////////////////////////////////////////////////////////////////////////

`include "stream_router_defs.svh"

package route_pkg;

    // a single port still needs one bit to carry an index
    localparam int DEST_W = (`ROUTER_NUM_PORTS > 1) ? $clog2(`ROUTER_NUM_PORTS) : 1;

    // index of the output port a packet goes to
    typedef logic [DEST_W-1:0] dest_t;

    // queue pointer with one extra wrap bit, used in binary and Gray form
    typedef logic [$clog2(`ROUTER_QUEUE_DEPTH):0] qptr_t;

endpackage

// ==== source/route_cdc_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// route_cdc_fifo
// dual-clock destination queue, write side on wr_clk, read side on rd_clk
// Gray-coded pointers cross through two-flop synchronizers
// first-word-fall-through read data, registered full and empty flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module route_cdc_fifo #(
    parameter int DEPTH = 4
) (
    input  logic             wr_clk,
    input  logic             rd_clk,
    input  logic             arst_n,
    input  route_pkg::dest_t wr_data,
    input  logic             wr_en,
    input  logic             rd_en,
    output route_pkg::dest_t rd_data,
    output logic             full,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    // Gray pointers of a full queue differ from each other in their two top bits
    localparam route_pkg::qptr_t FULL_MASK = route_pkg::qptr_t'(3) << (AW - 1);

    // storage, written on wr_clk and read asynchronously on rd_clk
    route_pkg::dest_t mem [DEPTH];

    // write domain pointers and the read pointer brought across
    route_pkg::qptr_t wr_bin;
    route_pkg::qptr_t wr_bin_next;
    route_pkg::qptr_t wr_gray;
    route_pkg::qptr_t wr_gray_next;
    route_pkg::qptr_t rd_gray_s1;
    route_pkg::qptr_t rd_gray_s2;

    // read domain pointers and the write pointer brought across
    route_pkg::qptr_t rd_bin;
    route_pkg::qptr_t rd_bin_next;
    route_pkg::qptr_t rd_gray;
    route_pkg::qptr_t rd_gray_next;
    route_pkg::qptr_t wr_gray_s1;
    route_pkg::qptr_t wr_gray_s2;

    function automatic route_pkg::qptr_t bin2gray(input route_pkg::qptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////

    // a write while full is dropped, the pointer does not move
    assign wr_bin_next  = wr_bin + route_pkg::qptr_t'(wr_en && !full);
    assign wr_gray_next = bin2gray(wr_bin_next);

    always_ff @(posedge wr_clk) begin
        if (wr_en && !full) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    // full is held high in reset so no destination is accepted before release
    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            full       <= 1'b1;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            full       <= (wr_gray_next == (rd_gray_s2 ^ FULL_MASK));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////////////

    // the head entry is visible as soon as empty is low
    assign rd_data      = mem[rd_bin[AW-1:0]];
    // a read while empty is ignored
    assign rd_bin_next  = rd_bin + route_pkg::qptr_t'(rd_en && !empty);
    assign rd_gray_next = bin2gray(rd_bin_next);

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            empty      <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            // empty clears two to three rd_clk cycles after the write
            empty      <= (rd_gray_next == wr_gray_s2);
        end
    end

endmodule

// ==== source/packet_valve.sv ====
////////////////////////////////////////////////////////////////////////////
// packet_valve
// one-entry stream register that opens only while a destination is queued
// tags each beat with the queue head and pops the head on tlast
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module packet_valve (
    input  logic              aclk,
    input  logic              arst_n,
    input  stream_pkg::data_t s_tdata,
    input  logic              s_tlast,
    input  logic              s_tvalid,
    output logic              s_tready,
    input  route_pkg::dest_t  q_dest,
    input  logic              q_empty,
    output logic              q_pop,
    output stream_pkg::data_t v_tdata,
    output logic              v_tlast,
    output logic              v_tvalid,
    output route_pkg::dest_t  v_dest,
    input  logic              v_tready
);

    // input handshake
    logic take;
    // output handshake
    logic drain;

    assign drain = v_tvalid && v_tready;

    // while a tlast beat sits in the register the queue head still belongs to
    // that packet, so the next packet waits until the pop has taken effect
    assign s_tready = !q_empty && (!v_tvalid || (drain && !v_tlast));
    assign take     = s_tvalid && s_tready;

    // the last beat leaving releases the destination of its packet
    assign q_pop = drain && v_tlast;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            v_tvalid <= 1'b0;
        end else if (take) begin
            v_tvalid <= 1'b1;
        end else if (drain) begin
            v_tvalid <= 1'b0;
        end
    end

    // beat and its destination are captured together and held under stall
    always_ff @(posedge aclk) begin
        if (take) begin
            v_tdata <= s_tdata;
            v_tlast <= s_tlast;
            v_dest  <= q_dest;
        end
    end

endmodule

// ==== source/stream_demux.sv ====
////////////////////////////////////////////////////////////////////////////
// stream_demux
// steers one stream to one of NUM_PORTS outputs selected by v_dest
// data and last are broadcast, valid and ready follow the selected port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module stream_demux #(
    parameter int NUM_PORTS = 4
) (
    input  stream_pkg::data_t     v_tdata,
    input  logic                  v_tlast,
    input  logic                  v_tvalid,
    input  route_pkg::dest_t      v_dest,
    output logic                  v_tready,
    output stream_pkg::data_t     m_tdata,
    output logic                  m_tlast,
    output stream_pkg::port_vec_t m_tvalid,
    input  stream_pkg::port_vec_t m_tready
);

    // one-hot decode of the destination, all zero for an index out of range
    stream_pkg::port_vec_t sel;

    always_comb begin
        sel = '0;
        for (int k = 0; k < $bits(stream_pkg::port_vec_t); k++) begin
            // ports beyond NUM_PORTS are never selected
            sel[k] = (k < NUM_PORTS) && (int'(v_dest) == k);
        end
    end

    // only the selected port sees a valid beat
    assign m_tvalid = sel & {$bits(stream_pkg::port_vec_t){v_tvalid}};

    // ready of the other ports is ignored, so an unselected port that is
    // stalled never holds up the stream
    // an out-of-range index leaves ready low and the beat waits in place
    assign v_tready = |(sel & m_tready);

    // shared payload, qualified per port by m_tvalid
    assign m_tdata = v_tdata;
    assign m_tlast = v_tlast;

endmodule

// ==== source/stream_router.sv ====
////////////////////////////////////////////////////////////////////////////
// stream_router
// routes packets of one stream input to one of several outputs
// destinations arrive on addr_clk through a dual-clock queue, data on aclk
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "stream_router_defs.svh"

module stream_router (
    input  logic                  addr_clk,
    input  logic                  aclk,
    input  logic                  arst_n,
    input  route_pkg::dest_t      dest,
    input  logic                  dest_valid,
    output logic                  dest_ready,
    input  stream_pkg::data_t     s_tdata,
    input  logic                  s_tlast,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    output stream_pkg::data_t     m_tdata,
    output logic                  m_tlast,
    output stream_pkg::port_vec_t m_tvalid,
    input  stream_pkg::port_vec_t m_tready
);

    // destination queue, write side in addr_clk
    logic              q_full;
    logic              q_wr_en;
    // destination queue, read side in aclk
    route_pkg::dest_t  q_dest;
    logic              q_empty;
    logic              q_pop;

    // registered stream between valve and demultiplexer
    stream_pkg::data_t v_tdata;
    logic              v_tlast;
    logic              v_tvalid;
    logic              v_tready;
    route_pkg::dest_t  v_dest;

    // a queue write is exactly one destination handshake
    assign dest_ready = !q_full;
    assign q_wr_en    = dest_valid && dest_ready;

    route_cdc_fifo #(
        .DEPTH   (`ROUTER_QUEUE_DEPTH)
    ) i_route_cdc_fifo (
        .wr_clk  (addr_clk),
        .rd_clk  (aclk),
        .arst_n  (arst_n),
        .wr_data (dest),
        .wr_en   (q_wr_en),
        .rd_en   (q_pop),
        .rd_data (q_dest),
        .full    (q_full),
        .empty   (q_empty)
    );

    // holds the packet back until its destination is known
    packet_valve i_packet_valve (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tdata  (s_tdata),
        .s_tlast  (s_tlast),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .q_dest   (q_dest),
        .q_empty  (q_empty),
        .q_pop    (q_pop),
        .v_tdata  (v_tdata),
        .v_tlast  (v_tlast),
        .v_tvalid (v_tvalid),
        .v_dest   (v_dest),
        .v_tready (v_tready)
    );

    stream_demux #(
        .NUM_PORTS (`ROUTER_NUM_PORTS)
    ) i_stream_demux (
        .v_tdata   (v_tdata),
        .v_tlast   (v_tlast),
        .v_tvalid  (v_tvalid),
        .v_dest    (v_dest),
        .v_tready  (v_tready),
        .m_tdata   (m_tdata),
        .m_tlast   (m_tlast),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready)
    );

endmodule

// ==== verification/stream_router_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// concurrent assertions bound to the stream router top
// one-hot output valid, stability under stall, valve gating, reset state
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module stream_router_assertions (
    input logic                  aclk,
    input logic                  arst_n,
    input logic                  q_empty,
    input logic                  s_tready,
    input logic                  dest_ready,
    input stream_pkg::data_t     m_tdata,
    input logic                  m_tlast,
    input stream_pkg::port_vec_t m_tvalid,
    input stream_pkg::port_vec_t m_tready
);

    // number of assertion failures, read by the testbench at the end
    int fail_count = 0;

    // at most one output port carries a beat at any time
    onehot_valid: assert property (@(posedge aclk) disable iff (!arst_n)
        $onehot0(m_tvalid))
        else begin
            fail_count++;
            $error("m_tvalid selects more than one port");
        end

    // a stalled beat keeps its port, data and last until it is taken
    hold_under_stall: assert property (@(posedge aclk) disable iff (!arst_n)
        (m_tvalid != '0) && ((m_tvalid & m_tready) == '0)
        |=> (m_tvalid == $past(m_tvalid)) && $stable(m_tdata) && $stable(m_tlast))
        else begin
            fail_count++;
            $error("stalled output beat changed before its handshake");
        end

    // no input beat is taken without a queued destination
    closed_when_empty: assert property (@(posedge aclk) disable iff (!arst_n)
        q_empty |-> !s_tready)
        else begin
            fail_count++;
            $error("s_tready is high while the destination queue is empty");
        end

    // the destination input stays closed during reset
    closed_in_reset: assert property (@(posedge aclk) !arst_n |-> !dest_ready)
        else begin
            fail_count++;
            $error("dest_ready is high during reset");
        end

endmodule

// ==== verification/stream_router_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench of the stream router
// clocks, reset, directed test tasks and a per-port scoreboard
// the assertion module is bound to the router top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "stream_router_defs.svh"

module stream_router_tb;

    localparam int NP      = `ROUTER_NUM_PORTS;
    localparam int DW      = `ROUTER_DATA_WIDTH;
    localparam int TIMEOUT = 400;

    logic                  aclk;
    logic                  addr_clk;
    logic                  arst_n;
    route_pkg::dest_t      dest;
    logic                  dest_valid;
    logic                  dest_ready;
    stream_pkg::data_t     s_tdata;
    logic                  s_tlast;
    logic                  s_tvalid;
    logic                  s_tready;
    stream_pkg::data_t     m_tdata;
    logic                  m_tlast;
    stream_pkg::port_vec_t m_tvalid;
    stream_pkg::port_vec_t m_tready;

    // expected {tlast, tdata} of every beat still owed to each port
    logic [DW:0] exp_q [NP][$];
    int          errors;
    int          checks;
    int          timeouts;
    // port of a packet whose tlast has not been seen yet, -1 when none
    int          open_port;
    logic [31:0] rng;

    stream_router i_stream_router (
        .addr_clk   (addr_clk),
        .aclk       (aclk),
        .arst_n     (arst_n),
        .dest       (dest),
        .dest_valid (dest_valid),
        .dest_ready (dest_ready),
        .s_tdata    (s_tdata),
        .s_tlast    (s_tlast),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .m_tdata    (m_tdata),
        .m_tlast    (m_tlast),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready)
    );

    bind stream_router stream_router_assertions i_stream_router_assertions (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .q_empty    (q_empty),
        .s_tready   (s_tready),
        .dest_ready (dest_ready),
        .m_tdata    (m_tdata),
        .m_tlast    (m_tlast),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready)
    );

    // 40 ns stream clock, the address clock follows it 13 ns later
    initial aclk = 1'b0;
    initial addr_clk = 1'b0;
    always #20 aclk = ~aclk;
    always @(aclk) addr_clk <= #13 aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int k = 0; k < NP; k++) begin
            total += exp_q[k].size();
        end
        return total;
    endfunction

    task automatic expect_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // compares one output handshake with the head of that port's queue
    task automatic check_beat(input int k);
        logic [DW:0] exp;
        if (exp_q[k].size() == 0) begin
            errors++;
            $display("beat on port %0d at %0t while no packet was sent there", k, $time);
        end else begin
            exp = exp_q[k].pop_front();
            expect_value($sformatf("m_tdata[port %0d]", k), m_tdata, exp[DW-1:0]);
            expect_value($sformatf("m_tlast[port %0d]", k), m_tlast, exp[DW]);
        end
        // a packet must end before the stream moves to another port
        if (open_port >= 0 && open_port != k) begin
            errors++;
            $display("port %0d started at %0t before packet on port %0d ended",
                     k, $time, open_port);
        end
        open_port = m_tlast ? -1 : k;
    endtask

    // outputs are sampled at the falling edge, half a cycle after they settle
    always @(negedge aclk) begin
        if (arst_n) begin
            for (int k = 0; k < NP; k++) begin
                if (m_tvalid[k] && m_tready[k]) begin
                    check_beat(k);
                end
            end
        end
    end

    task automatic send_dest(input int port);
        int n;
        @(posedge addr_clk);
        #2;
        dest       = route_pkg::dest_t'(port);
        dest_valid = 1'b1;
        n = 0;
        @(negedge addr_clk);
        while (!dest_ready && n < TIMEOUT) begin
            @(negedge addr_clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            note_timeout($sformatf("destination %0d was never accepted", port));
        end
        @(posedge addr_clk);
        #2;
        dest_valid = 1'b0;
    endtask

    // queues the expected beats and drives one packet with random data
    task automatic send_packet(input int port, input int len);
        stream_pkg::data_t data;
        int n;
        for (int b = 0; b < len; b++) begin
            rng  = lcg_next(rng);
            data = stream_pkg::data_t'(rng);
            exp_q[port].push_back({b == len - 1, data});
            @(posedge aclk);
            #2;
            s_tdata  = data;
            s_tlast  = (b == len - 1);
            s_tvalid = 1'b1;
            n = 0;
            @(negedge aclk);
            while (!s_tready && n < TIMEOUT) begin
                @(negedge aclk);
                n++;
            end
            if (n >= TIMEOUT) begin
                note_timeout($sformatf("beat %0d of a packet to port %0d not taken", b, port));
                s_tvalid = 1'b0;
                return;
            end
        end
        @(posedge aclk);
        #2;
        s_tvalid = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pending_beats() != 0 && n < TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (n >= TIMEOUT) begin
            note_timeout($sformatf("%0d expected beats never arrived", pending_beats()));
        end
    endtask

    task automatic wait_dest_ready();
        int n;
        n = 0;
        while (!dest_ready && n < TIMEOUT) begin
            @(negedge addr_clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            note_timeout("dest_ready never rose");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        @(negedge aclk);
        expect_value("m_tvalid", m_tvalid, 0);
        expect_value("s_tready", s_tready, 0);
        wait_dest_ready();
    endtask

    task automatic single_beat_routing();
        for (int p = 0; p < NP; p++) begin
            send_dest(p);
            send_packet(p, 1);
        end
        wait_drained();
    endtask

    // all destinations go first, the packets then follow in the same order
    task automatic multi_beat_order();
        int order [4] = '{2, 0, 3, 1};
        int lens [4]  = '{3, 2, 4, 1};
        for (int i = 0; i < 4; i++) begin
            send_dest(order[i] % NP);
        end
        for (int i = 0; i < 4; i++) begin
            send_packet(order[i] % NP, lens[i]);
        end
        wait_drained();
    endtask

    task automatic data_waits_for_dest();
        fork
            send_packet(1, 2);
            begin
                repeat (10) begin
                    @(negedge aclk);
                    expect_value("s_tready", s_tready, 0);
                    expect_value("m_tvalid", m_tvalid, 0);
                end
                send_dest(1);
            end
        join
        wait_drained();
    endtask

    task automatic back_pressure();
        stream_pkg::data_t held;
        int n;
        @(posedge aclk);
        #2;
        m_tready[2] = 1'b0;
        fork
            send_dest(2);
            send_packet(2, 3);
            begin
                n = 0;
                while (!m_tvalid[2] && n < TIMEOUT) begin
                    @(negedge aclk);
                    n++;
                end
                if (n >= TIMEOUT) begin
                    note_timeout("stalled packet never reached port 2");
                end
                // data of the first beat that was sent to port 2
                held = exp_q[2][0][DW-1:0];
                // the first beat sits in the valve and the input stalls
                repeat (8) begin
                    @(negedge aclk);
                    expect_value("m_tvalid", m_tvalid, 4'b0100);
                    expect_value("m_tdata", m_tdata, held);
                    expect_value("s_tready", s_tready, 0);
                end
                @(posedge aclk);
                #2;
                m_tready[2] = 1'b1;
            end
        join
        wait_drained();
        // fill the queue with no packet behind it
        for (int i = 0; i < `ROUTER_QUEUE_DEPTH; i++) begin
            send_dest(i % NP);
        end
        repeat (3) @(negedge addr_clk);
        expect_value("dest_ready", dest_ready, 0);
        send_packet(0, 2);
        wait_drained();
        wait_dest_ready();
        for (int i = 1; i < `ROUTER_QUEUE_DEPTH; i++) begin
            send_packet(i % NP, 1);
        end
        wait_drained();
    endtask

    task automatic random_traffic();
        int          dest_list [24];
        int          len_list [24];
        logic [31:0] rdy_state;
        logic        done;
        for (int i = 0; i < 24; i++) begin
            rng          = lcg_next(rng);
            dest_list[i] = (rng >> 16) % NP;
            rng          = lcg_next(rng);
            len_list[i]  = 1 + (rng >> 16) % 5;
        end
        rdy_state = lcg_next(rng);
        done      = 1'b0;
        fork
            for (int i = 0; i < 24; i++) begin
                send_dest(dest_list[i]);
            end
            begin
                for (int i = 0; i < 24; i++) begin
                    send_packet(dest_list[i], len_list[i]);
                end
                wait_drained();
                done = 1'b1;
            end
            while (!done) begin
                @(posedge aclk);
                #2;
                rdy_state = lcg_next(rdy_state);
                m_tready  = stream_pkg::port_vec_t'(rdy_state >> 16);
            end
        join
        m_tready = '1;
        expect_value("pending beats", pending_beats(), 0);
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        open_port  = -1;
        rng        = 32'd71069;
        arst_n     = 1'b1;
        dest       = '0;
        dest_valid = 1'b0;
        s_tdata    = '0;
        s_tlast    = 1'b0;
        s_tvalid   = 1'b0;
        m_tready   = '1;
        #1;
        arst_n = 1'b0;
        repeat (16) @(posedge aclk);
        expect_value("dest_ready", dest_ready, 0);
        #2;
        arst_n = 1'b1;

        reset_values();
        single_beat_routing();
        multi_beat_order();
        data_waits_for_dest();
        back_pressure();
        random_traffic();

        repeat (4) @(posedge aclk);
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts,
                 i_stream_router.i_stream_router_assertions.fail_count);
        if (errors == 0 && timeouts == 0 &&
            i_stream_router.i_stream_router_assertions.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/stream_pkg.sv
source/route_pkg.sv
source/route_cdc_fifo.sv
source/packet_valve.sv
source/stream_demux.sv
source/stream_router.sv
verification/stream_router_assertions.sv
verification/stream_router_tb.sv

// ==== Bender.yml ====
package:
  name: stream_router

sources:
  - include_dirs:
      - source
    files:
      - source/stream_pkg.sv
      - source/route_pkg.sv
      - source/route_cdc_fifo.sv
      - source/packet_valve.sv
      - source/stream_demux.sv
      - source/stream_router.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/stream_router_assertions.sv
      - verification/stream_router_tb.sv
